// ==== common/core_regs_pkg.sv ====
// Settings bus, register map and control-line types used by the control plane modules
package core_regs_pkg;

   //////////////////////////////////////////////////
   // Settings bus

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef struct packed {
      logic                  stb;    // Single-cycle write strobe
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } setting_bus_t;

   // Register group bases
   localparam logic [SET_ADDR_W-1:0] SR_MISC   = 8'd0;    // 7 regs
   localparam logic [SET_ADDR_W-1:0] SR_TIME64 = 8'd10;   // 3 regs

   //////////////////////////////////////////////////
   // Control lines

   // Clock generator
   typedef struct packed {
      logic       ready;
      logic [1:0] en;
      logic [1:0] sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   // Both ADC channels
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;   // Status LEDs on hardware

   //////////////////////////////////////////////////
   // Readback

   // Word indices that carry data, the rest read zero
   typedef enum logic [3:0] {
      RB_TIME_SECS  = 4'd10,
      RB_TIME_TICKS = 4'd11,
      RB_COMPAT     = 4'd12,
      RB_PPS_SECS   = 4'd14,
      RB_PPS_TICKS  = 4'd15
   } rb_word_e;

   // Bump when the register map or behavior changes
   localparam logic [31:0] COMPAT_NUM = {16'd7, 16'd1};   // Major, minor

endpackage

// ==== common/vita_time_pkg.sv ====
// VITA time format, load modes and timekeeper states shared by the timing logic
package vita_time_pkg;

   // Seconds in the upper word
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   localparam logic [31:0] TICKS_PER_SEC_DEFAULT = 32'd100000000;   // 100 MHz dsp_clk

   //////////////////////////////////////////////////
   // Load control

   // Bit 0 of the mode write
   typedef enum logic {
      LOAD_NOW    = 1'b0,
      LOAD_ON_PPS = 1'b1
   } time_load_e;

   typedef enum logic {
      TK_IDLE  = 1'b0,
      TK_ARMED = 1'b1   // Waiting for PPS to apply the load
   } timekeeper_state_e;

endpackage

// ==== verilog/setting_reg.sv ====
// Single settings-bus register, loaded when a strobe hits its address
`timescale 1ns/10ps

module setting_reg #(
   parameter logic [core_regs_pkg::SET_ADDR_W-1:0] my_addr = '0,
   parameter int                                   width = 32,
   parameter logic [width-1:0]                     at_reset = '0
) (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  core_regs_pkg::setting_bus_t set_bus_i,
   output logic [width-1:0]            out_o
);

   logic hit;

   assign hit = set_bus_i.stb && (set_bus_i.addr == my_addr);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o <= at_reset;
      end else if (hit) begin
         out_o <= set_bus_i.data[width-1:0];   // Low bits only
      end
   end

   // Value moves only as a result of a write to this address
   a_write_only: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      !$past(hit) |-> $stable(out_o)
   ) else $error("setting_reg %0d changed without a write", my_addr);

endmodule

// ==== verilog/misc_ctrl.sv ====
// Miscellaneous control registers of the SR_MISC group and the status LED source mux
`timescale 1ns/10ps

module misc_ctrl (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  core_regs_pkg::setting_bus_t set_bus_i,
   input  logic                        run_tx_i,
   input  logic                        run_rx_i,
   input  logic                        clk_status_i,
   input  logic                        link_up_i,
   output core_regs_pkg::clock_ctrl_t  clock_ctrl_o,
   output core_regs_pkg::serdes_ctrl_t serdes_ctrl_o,
   output core_regs_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                        phy_resetn_o,
   output logic [7:0]                  leds_o
);

   localparam int CLK_W = $bits(core_regs_pkg::clock_ctrl_t);
   localparam int SER_W = $bits(core_regs_pkg::serdes_ctrl_t);
   localparam int ADC_W = $bits(core_regs_pkg::adc_ctrl_t);

   logic [CLK_W-1:0] clock_bits;
   logic [SER_W-1:0] serdes_bits;
   logic [ADC_W-1:0] adc_bits;
   logic             phy_reset;
   logic [7:0]       led_sw;
   logic [7:0]       led_src;
   logic [7:0]       led_hw;
   logic             led_sw_hit;

   //////////////////////////////////////////////////
   // Control registers

   setting_reg #(.my_addr(core_regs_pkg::SR_MISC + 8'd0), .width(CLK_W)) sr_clk (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(clock_bits)
   );

   setting_reg #(.my_addr(core_regs_pkg::SR_MISC + 8'd1), .width(SER_W)) sr_ser (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(serdes_bits)
   );

   setting_reg #(.my_addr(core_regs_pkg::SR_MISC + 8'd2), .width(ADC_W)) sr_adc (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(adc_bits)
   );

   setting_reg #(.my_addr(core_regs_pkg::SR_MISC + 8'd4), .width(1)) sr_phy (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(phy_reset)
   );

   assign clock_ctrl_o  = core_regs_pkg::clock_ctrl_t'(clock_bits);
   assign serdes_ctrl_o = core_regs_pkg::serdes_ctrl_t'(serdes_bits);
   assign adc_ctrl_o    = core_regs_pkg::adc_ctrl_t'(adc_bits);
   assign phy_resetn_o  = ~phy_reset;   // PHY reset pin is active low

   //////////////////////////////////////////////////
   // LEDs
   // Source bit 1 selects hardware status, 0 the software value

   setting_reg #(.my_addr(core_regs_pkg::SR_MISC + 8'd3), .width(8)) sr_led_sw (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(led_sw)
   );

   setting_reg #(
      .my_addr (core_regs_pkg::SR_MISC + 8'd6),
      .width   (8),
      .at_reset(core_regs_pkg::LED_SRC_RESET)
   ) sr_led_src (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i), .out_o(led_src)
   );

   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign led_sw_hit = set_bus_i.stb && (set_bus_i.addr == core_regs_pkg::SR_MISC + 8'd3);

   // Software-owned LEDs show the written value the cycle after the write
   a_led_sw: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      led_sw_hit |=> ((leds_o & ~led_src) == ($past(set_bus_i.data[7:0]) & ~led_src))
   ) else $error("LED software bits do not follow led_sw write");

endmodule

// ==== vita_time/vita_timekeeper.sv ====
// VITA seconds/ticks timekeeper with immediate or PPS-aligned load and PPS time capture
`timescale 1ns/10ps

module vita_timekeeper #(
   parameter logic [31:0] ticks_per_sec = vita_time_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  core_regs_pkg::setting_bus_t set_bus_i,
   input  logic                        pps_i,
   output vita_time_pkg::vita_time_t   vita_time_o,
   output vita_time_pkg::vita_time_t   vita_time_pps_o,
   output logic                        pps_int_o
);

   vita_time_pkg::vita_time_t         load_time;   // Staged secs/ticks
   vita_time_pkg::vita_time_t         time_next;
   vita_time_pkg::timekeeper_state_e  state;
   vita_time_pkg::time_load_e         load_mode;
   logic                              secs_hit;
   logic                              ticks_hit;
   logic                              mode_hit;
   logic [2:0]                        pps_sr;
   logic                              pps_evt;

   //////////////////////////////////////////////////
   // Settings decode

   assign secs_hit  = set_bus_i.stb && (set_bus_i.addr == core_regs_pkg::SR_TIME64 + 8'd0);
   assign ticks_hit = set_bus_i.stb && (set_bus_i.addr == core_regs_pkg::SR_TIME64 + 8'd1);
   assign mode_hit  = set_bus_i.stb && (set_bus_i.addr == core_regs_pkg::SR_TIME64 + 8'd2);
   assign load_mode = vita_time_pkg::time_load_e'(set_bus_i.data[0]);

   always_ff @(posedge dsp_clk) begin
      if (secs_hit) begin
         load_time.secs <= set_bus_i.data;
      end
      if (ticks_hit) begin
         load_time.ticks <= set_bus_i.data;
      end
   end

   //////////////////////////////////////////////////
   // PPS sync and edge detect

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sr  <= '0;
         pps_evt <= 1'b0;
      end else begin
         pps_sr  <= {pps_sr[1:0], pps_i};     // Two sync stages plus a delay tap
         pps_evt <= pps_sr[1] & ~pps_sr[2];   // Rising edge, one cycle wide
      end
   end

   assign pps_int_o = pps_evt;

   //////////////////////////////////////////////////
   // Counter and loads

   always_comb begin
      time_next = vita_time_o;
      if (vita_time_o.ticks == ticks_per_sec - 32'd1) begin
         time_next.secs  = vita_time_o.secs + 32'd1;   // Rollover
         time_next.ticks = '0;
      end else begin
         time_next.ticks = vita_time_o.ticks + 32'd1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         state           <= vita_time_pkg::TK_IDLE;
      end else begin
         if (mode_hit && load_mode == vita_time_pkg::LOAD_NOW) begin
            vita_time_o <= load_time;
         end else if (pps_evt && state == vita_time_pkg::TK_ARMED) begin
            vita_time_o <= load_time;   // PPS-aligned load
         end else begin
            vita_time_o <= time_next;
         end

         // PPS time is the value shown while pps_int_o is high, or the load
         if (pps_evt) begin
            vita_time_pps_o <= (state == vita_time_pkg::TK_ARMED) ? load_time : vita_time_o;
         end

         if (mode_hit) begin
            state <= (load_mode == vita_time_pkg::LOAD_ON_PPS) ?
                     vita_time_pkg::TK_ARMED : vita_time_pkg::TK_IDLE;
         end else if (pps_evt) begin
            state <= vita_time_pkg::TK_IDLE;
         end
      end
   end

   a_ticks_range: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      vita_time_o.ticks < ticks_per_sec
   ) else $error("ticks out of range: %0d", vita_time_o.ticks);

   a_pps_pulse: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o
   ) else $error("pps_int_o held for more than one cycle");

endmodule

// ==== verilog/readback_mux.sv ====
// Registered sixteen-word readback of time, PPS time and compatibility number
`timescale 1ns/10ps

module readback_mux (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      rb_stb_i,
   input  logic [3:0]                rb_addr_i,
   input  vita_time_pkg::vita_time_t vita_time_i,
   input  vita_time_pkg::vita_time_t vita_time_pps_i,
   output logic [31:0]               rb_data_o,
   output logic                      rb_ack_o
);

   logic [31:0] word_sel;

   // Words of dropped functions fall to zero
   always_comb begin
      case (core_regs_pkg::rb_word_e'(rb_addr_i))
         core_regs_pkg::RB_TIME_SECS:  word_sel = vita_time_i.secs;
         core_regs_pkg::RB_TIME_TICKS: word_sel = vita_time_i.ticks;
         core_regs_pkg::RB_COMPAT:     word_sel = core_regs_pkg::COMPAT_NUM;
         core_regs_pkg::RB_PPS_SECS:   word_sel = vita_time_pps_i.secs;
         core_regs_pkg::RB_PPS_TICKS:  word_sel = vita_time_pps_i.ticks;
         default:                      word_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= word_sel;   // Sampled at the strobe edge
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   a_ack_follows_stb: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      rb_ack_o |-> $past(rb_stb_i)
   ) else $error("rb_ack_o without a strobe");

endmodule

// ==== verilog/core_ctrl_top.sv ====
// Top level of the dsp_clk control plane, connecting control registers, timekeeper and readback
`timescale 1ns/10ps

module core_ctrl_top #(
   parameter logic [31:0] ticks_per_sec = vita_time_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   // Settings and readback
   input  core_regs_pkg::setting_bus_t set_bus_i,
   input  logic                        rb_stb_i,
   input  logic [3:0]                  rb_addr_i,
   output logic [31:0]                 rb_data_o,
   output logic                        rb_ack_o,
   // Status for the LEDs
   input  logic                        run_tx_i,
   input  logic                        run_rx_i,
   input  logic                        clk_status_i,
   input  logic                        link_up_i,
   // Timing
   input  logic                        pps_i,
   output vita_time_pkg::vita_time_t   vita_time_o,
   output logic                        pps_int_o,
   // Control lines
   output core_regs_pkg::clock_ctrl_t  clock_ctrl_o,
   output core_regs_pkg::serdes_ctrl_t serdes_ctrl_o,
   output core_regs_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                        phy_resetn_o,
   output logic [7:0]                  leds_o
);

   vita_time_pkg::vita_time_t vita_time_pps;

   misc_ctrl misc_ctrl0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .phy_resetn_o(phy_resetn_o), .leds_o(leds_o)
   );

   vita_timekeeper #(.ticks_per_sec(ticks_per_sec)) timekeeper0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus_i),
      .pps_i(pps_i), .vita_time_o(vita_time_o),
      .vita_time_pps_o(vita_time_pps), .pps_int_o(pps_int_o)
   );

   readback_mux readback0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time_o), .vita_time_pps_i(vita_time_pps),
      .rb_data_o(rb_data_o), .rb_ack_o(rb_ack_o)
   );

endmodule

// ==== tb/core_ctrl_tb.sv ====
// Self-checking testbench for core_ctrl_top; compile with all.f and run core_ctrl_tb as top
`timescale 1ns/10ps

module core_ctrl_tb;

   localparam int          CLK_NS     = 100;
   localparam logic [31:0] TB_TICKS   = 32'd16;             // Short seconds for rollovers
   localparam logic [31:0] EXP_COMPAT = {16'd7, 16'd1};
   localparam int          CTRL_LEN   = 60;
   localparam int          LED_LEN    = 60;
   localparam int          LOAD_LEN   = 4;
   localparam int          PPS_LEN    = 3;
   // Worst case cycles of each test, then margin
   localparam int RUN_CYCLES = 20 + CTRL_LEN * 3 + LED_LEN * 6 + LOAD_LEN * 50
                               + PPS_LEN * 60 + 80;
   localparam int WATCHDOG_CYCLES = RUN_CYCLES + 500;

   logic                        dsp_clk;
   logic                        por_rst;
   core_regs_pkg::setting_bus_t set_bus;
   logic                        rb_stb;
   logic [3:0]                  rb_addr;
   logic [31:0]                 rb_data;
   logic                        rb_ack;
   logic                        run_tx;
   logic                        run_rx;
   logic                        clk_status;
   logic                        link_up;
   logic                        pps;
   vita_time_pkg::vita_time_t   vita_time;
   logic                        pps_int;
   core_regs_pkg::clock_ctrl_t  clock_ctrl;
   core_regs_pkg::serdes_ctrl_t serdes_ctrl;
   core_regs_pkg::adc_ctrl_t    adc_ctrl;
   logic                        phy_resetn;
   logic [7:0]                  leds;
   string                       test_name;
   int                          value_errs;
   int                          event_errs;
   int                          timeout_errs;

   core_ctrl_top #(.ticks_per_sec(TB_TICKS)) dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus),
      .rb_stb_i(rb_stb), .rb_addr_i(rb_addr), .rb_data_o(rb_data), .rb_ack_o(rb_ack),
      .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status), .link_up_i(link_up),
      .pps_i(pps), .vita_time_o(vita_time), .pps_int_o(pps_int),
      .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_resetn_o(phy_resetn), .leds_o(leds)
   );

   initial begin
      dsp_clk = 1'b0;
      forever begin
         #(CLK_NS / 2) dsp_clk = ~dsp_clk;
      end
   end

   //////////////////////////////////////////////////
   // Reference model

   // status holds run_tx, run_rx, clk_status, link_up
   function automatic logic [7:0] ref_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input logic [3:0] status);
      logic [7:0] hw;
      logic [7:0] res;
      hw = {3'b000, status, 1'b0};
      for (int b = 0; b < 8; b++) begin
         res[b] = src[b] ? hw[b] : sw[b];
      end
      return res;
   endfunction

   function automatic vita_time_pkg::vita_time_t ref_next_time(input vita_time_pkg::vita_time_t t);
      vita_time_pkg::vita_time_t n;
      n = t;
      n.ticks = t.ticks + 32'd1;
      if (n.ticks == TB_TICKS) begin   // Wrap into the next second
         n.ticks = '0;
         n.secs  = t.secs + 32'd1;
      end
      return n;
   endfunction

   function automatic logic [31:0] ref_rb_word(input logic [3:0] idx,
                                               input vita_time_pkg::vita_time_t t,
                                               input vita_time_pkg::vita_time_t p);
      case (idx)
         4'd10:   return t.secs;
         4'd11:   return t.ticks;
         4'd12:   return EXP_COMPAT;
         4'd14:   return p.secs;
         4'd15:   return p.ticks;
         default: return 32'd0;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         value_errs++;
         $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      end
   endtask

   //////////////////////////////////////////////////
   // Comparison, once per cycle after the falling edge

   initial begin : compare
      vita_time_pkg::vita_time_t   m_time, m_pps, m_stage;
      core_regs_pkg::setting_bus_t p_bus;
      logic [4:0]                  m_clk;
      logic [3:0]                  m_ser, m_adc, p_rb_addr;
      logic [7:0]                  m_led_sw, m_led_src;
      logic [31:0]                 exp_rb;
      logic                        m_phy, m_armed, exp_ack, exp_phyn, mode_wr;
      logic                        p_rst, p_rb_stb, p_pps_int, p_pps;
      int                          pps_pending;
      p_rst       = 1'b1;   // First edge runs in reset
      p_bus       = '0;
      p_rb_stb    = 1'b0;
      p_rb_addr   = '0;
      p_pps_int   = 1'b0;
      p_pps       = 1'b0;
      pps_pending = 0;
      m_stage     = '0;
      forever begin
         @(negedge dsp_clk);
         #(CLK_NS / 5);
         mode_wr = p_bus.stb && p_bus.addr == core_regs_pkg::SR_TIME64 + 8'd2;
         if (p_rst) begin
            m_time    = '0;
            m_pps     = '0;
            m_armed   = 1'b0;
            m_clk     = '0;
            m_ser     = '0;
            m_adc     = '0;
            m_phy     = 1'b0;
            m_led_sw  = '0;
            m_led_src = core_regs_pkg::LED_SRC_RESET;
            exp_ack   = 1'b0;
         end else begin
            exp_rb  = ref_rb_word(p_rb_addr, m_time, m_pps);   // Word at the strobe edge
            exp_ack = p_rb_stb;
            if (p_pps_int) begin
               m_pps = m_armed ? m_stage : m_time;
            end
            if (mode_wr && p_bus.data[0] == vita_time_pkg::LOAD_NOW) begin
               m_time = m_stage;
            end else if (p_pps_int && m_armed) begin
               m_time = m_stage;
            end else begin
               m_time = ref_next_time(m_time);
            end
            if (mode_wr) begin
               m_armed = (p_bus.data[0] == vita_time_pkg::LOAD_ON_PPS);
            end else if (p_pps_int) begin
               m_armed = 1'b0;
            end
            if (p_bus.stb) begin
               case (p_bus.addr)
                  core_regs_pkg::SR_MISC + 8'd0: m_clk     = p_bus.data[4:0];
                  core_regs_pkg::SR_MISC + 8'd1: m_ser     = p_bus.data[3:0];
                  core_regs_pkg::SR_MISC + 8'd2: m_adc     = p_bus.data[3:0];
                  core_regs_pkg::SR_MISC + 8'd3: m_led_sw  = p_bus.data[7:0];
                  core_regs_pkg::SR_MISC + 8'd4: m_phy     = p_bus.data[0];
                  core_regs_pkg::SR_MISC + 8'd6: m_led_src = p_bus.data[7:0];
                  default: ;
               endcase
            end
         end
         // Staged time has no reset
         if (p_bus.stb && p_bus.addr == core_regs_pkg::SR_TIME64) begin
            m_stage.secs = p_bus.data;
         end
         if (p_bus.stb && p_bus.addr == core_regs_pkg::SR_TIME64 + 8'd1) begin
            m_stage.ticks = p_bus.data;
         end
         exp_phyn = ~m_phy;
         check_value("vita_time", m_time, vita_time);
         check_value("clock_ctrl", m_clk, clock_ctrl);
         check_value("serdes_ctrl", m_ser, serdes_ctrl);
         check_value("adc_ctrl", m_adc, adc_ctrl);
         check_value("phy_resetn", exp_phyn, phy_resetn);
         check_value("leds", ref_leds(m_led_src, m_led_sw, {run_tx, run_rx, clk_status, link_up}),
                     leds);
         check_value("rb_ack", exp_ack, rb_ack);
         if (exp_ack) begin
            check_value($sformatf("rb_data[%0d]", p_rb_addr), exp_rb, rb_data);
         end
         // Each PPS edge owes exactly one interrupt pulse
         if (pps && !p_pps) begin
            pps_pending++;
         end
         if (pps_int) begin
            assert (pps_pending > 0) else begin
               event_errs++;
               $display("Unexpected pps_int_o pulse in %s with no PPS edge waiting for one",
                        test_name);
            end
            if (pps_pending > 0) begin
               pps_pending--;
            end
         end
         p_rst     = por_rst;
         p_bus     = set_bus;
         p_rb_stb  = rb_stb;
         p_rb_addr = rb_addr;
         p_pps_int = pps_int;
         p_pps     = pps;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus tasks, all driving on the falling edge

   task automatic idle(input int n);
      repeat (n) @(negedge dsp_clk);
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge dsp_clk);
      set_bus.stb  = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] idx);
      @(negedge dsp_clk);
      rb_stb  = 1'b1;
      rb_addr = idx;
      @(negedge dsp_clk);
      rb_stb  = 1'b0;
   endtask

   task automatic request_load(input logic [31:0] secs, input logic [31:0] ticks,
                               input vita_time_pkg::time_load_e mode);
      write_setting(core_regs_pkg::SR_TIME64, secs);
      write_setting(core_regs_pkg::SR_TIME64 + 8'd1, ticks);
      write_setting(core_regs_pkg::SR_TIME64 + 8'd2, {31'd0, mode});
   endtask

   // Hold PPS high until the interrupt shows up
   task automatic pulse_pps();
      logic seen;
      seen = 1'b0;
      @(negedge dsp_clk);
      pps = 1'b1;
      for (int n = 0; n < 8 && !seen; n++) begin
         @(negedge dsp_clk);
         seen = pps_int;
      end
      pps = 1'b0;
      if (!seen) begin
         timeout_errs++;
         $display("Timeout in %s: no PPS interrupt within 8 cycles of the PPS edge", test_name);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial begin : stimulus
      logic [7:0] addr;
      int         r;
      r            = $urandom(32'h12c3);
      value_errs   = 0;
      event_errs   = 0;
      timeout_errs = 0;
      test_name    = "reset";
      por_rst      = 1'b1;
      set_bus      = '0;
      rb_stb       = 1'b0;
      rb_addr      = '0;
      {run_tx, run_rx, clk_status, link_up} = 4'b0000;
      pps          = 1'b0;
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
      idle(3);

      test_name = "ctrl_regs";
      for (int i = 0; i < CTRL_LEN; i++) begin
         r = $urandom_range(0, 5);
         case (r)
            0, 1, 2: addr = core_regs_pkg::SR_MISC + 8'(r);
            3:       addr = core_regs_pkg::SR_MISC + 8'd4;
            4:       addr = core_regs_pkg::SR_MISC + 8'd5;   // Unused offset
            default: addr = 8'd13 + 8'($urandom_range(0, 240));
         endcase
         write_setting(addr, $urandom());
         idle($urandom_range(0, 1));
      end

      test_name = "led_mux";
      for (int i = 0; i < LED_LEN; i++) begin
         @(negedge dsp_clk);
         {run_tx, run_rx, clk_status, link_up} = 4'($urandom());
         addr = core_regs_pkg::SR_MISC + ((i % 2 == 0) ? 8'd3 : 8'd6);
         write_setting(addr, $urandom());
         idle($urandom_range(0, 2));
      end

      test_name = "load_now";
      for (int i = 0; i < LOAD_LEN; i++) begin
         request_load($urandom(), $urandom_range(0, 15), vita_time_pkg::LOAD_NOW);
         idle(40);
      end

      test_name = "pps_load";
      for (int i = 0; i < PPS_LEN; i++) begin
         request_load($urandom(), $urandom_range(0, 15), vita_time_pkg::LOAD_ON_PPS);
         idle(10);
         pulse_pps();
         read_word(core_regs_pkg::RB_PPS_SECS);
         read_word(core_regs_pkg::RB_PPS_TICKS);
         idle(20);
      end

      test_name = "readback";
      for (int idx = 0; idx < 16; idx++) begin   // Back-to-back strobes
         @(negedge dsp_clk);
         rb_stb  = 1'b1;
         rb_addr = 4'(idx);
      end
      @(negedge dsp_clk);
      rb_stb = 1'b0;
      idle(5);
      pulse_pps();
      read_word(core_regs_pkg::RB_PPS_SECS);
      read_word(core_regs_pkg::RB_PPS_TICKS);
      read_word(core_regs_pkg::RB_TIME_SECS);
      read_word(core_regs_pkg::RB_TIME_TICKS);
      idle(5);

      $display("Checks done: %0d value errors, %0d event errors, %0d timeouts",
               value_errs, event_errs, timeout_errs);
      if (value_errs == 0 && event_errs == 0 && timeout_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
common/core_regs_pkg.sv
common/vita_time_pkg.sv
verilog/setting_reg.sv
verilog/misc_ctrl.sv
vita_time/vita_timekeeper.sv
verilog/readback_mux.sv
verilog/core_ctrl_top.sv
tb/core_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: core_ctrl

sources:
  # Packages first, then the RTL bottom up
  - common/core_regs_pkg.sv
  - common/vita_time_pkg.sv
  - verilog/setting_reg.sv
  - verilog/misc_ctrl.sv
  - vita_time/vita_timekeeper.sv
  - verilog/readback_mux.sv
  - verilog/core_ctrl_top.sv

  # Testbench, top module core_ctrl_tb
  - target: test
    files:
      - tb/core_ctrl_tb.sv
